//--- mips_pkg.sv
// shared types and encodings for the single-cycle mips core, referenced by package::name
`default_nettype none

package mips_pkg;

   // field widths
   parameter int WORD_W   = 32;
   parameter int OP_W     = 6;
   parameter int REG_W    = 5;
   parameter int SHAMT_W  = 5;
   parameter int IMM_W    = 16;
   parameter int TARGET_W = 26;

   typedef logic [WORD_W-1:0] word_t;    // data word
   typedef logic [REG_W-1:0]  reg_idx_t; // register number

   // primary opcodes kept by this core
   typedef enum logic [OP_W-1:0] {
      OP_RTYPE = 6'h00,
      OP_J     = 6'h02,
      OP_JAL   = 6'h03,
      OP_BEQ   = 6'h04,
      OP_BNE   = 6'h05,
      OP_ADDI  = 6'h08,
      OP_ADDIU = 6'h09,
      OP_SLTI  = 6'h0a,
      OP_ANDI  = 6'h0c,
      OP_ORI   = 6'h0d,
      OP_XORI  = 6'h0e,
      OP_LUI   = 6'h0f,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2b
   } opcode_t;

   // r-type secondary opcodes
   typedef enum logic [OP_W-1:0] {
      FN_SLL     = 6'h00,
      FN_SRL     = 6'h02,
      FN_SRA     = 6'h03,
      FN_SLLV    = 6'h04,
      FN_SRLV    = 6'h06,
      FN_SRAV    = 6'h07,
      FN_JR      = 6'h08,
      FN_JALR    = 6'h09,
      FN_SYSCALL = 6'h0c,
      FN_ADD     = 6'h20,
      FN_ADDU    = 6'h21,
      FN_SUB     = 6'h22,
      FN_SUBU    = 6'h23,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a
   } funct_t;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV,
      ALU_SRAV, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT
   } alu_op_t;

   typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_REG, PC_JUMP} pc_sel_t;

   typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_LINK} wb_sel_t;

   // decoded control, all zero means no-op
   typedef struct packed {
      alu_op_t alu_op;
      logic    reg_we;
      logic    dst_rd;    // rd instead of rt
      logic    link;      // force r31
      logic    use_imm;
      logic    sign_ext;
      logic    shift_imm; // shamt shifts
      logic    lui;
      wb_sel_t wb_sel;
      logic    mem_we;
      logic    branch;
      logic    branch_ne;
      logic    jump;
      logic    jump_reg;
      logic    syscall;
   } ctrl_t;

   typedef struct packed {
      opcode_t               op;
      reg_idx_t              rs;
      reg_idx_t              rt;
      reg_idx_t              rd;
      logic [SHAMT_W-1:0]    shamt;
      funct_t                funct;
      logic [IMM_W-1:0]      imm;
      logic [TARGET_W-1:0]   target;
   } fields_t;

   parameter reg_idx_t V0_REG = 5'd2;
   parameter reg_idx_t RA_REG = 5'd31;

   parameter word_t SYSCALL_EXIT = 32'd10; // v0 value that stops the core

endpackage

`default_nettype wire

//--- mips_alu.sv
// combinational alu of the core, arithmetic, logic, shifts and signed set-less-than
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
   input  mips_pkg::alu_op_t              op,
   input  mips_pkg::word_t                a,
   input  mips_pkg::word_t                b,
   input  logic [mips_pkg::SHAMT_W-1:0]   shamt,
   output mips_pkg::word_t                result
);

   logic [mips_pkg::SHAMT_W-1:0] var_amt;
   logic                         lt;

   assign var_amt = a[mips_pkg::SHAMT_W-1:0]; // rs low bits for sllv etc
   assign lt      = $signed(a) < $signed(b);

   always_comb begin
      case (op)
         mips_pkg::ALU_ADD:  result = a + b;
         mips_pkg::ALU_SUB:  result = a - b;
         // immediate shifts, core puts rt on a
         mips_pkg::ALU_SLL:  result = a << shamt;
         mips_pkg::ALU_SRL:  result = a >> shamt;
         mips_pkg::ALU_SRA:  result = mips_pkg::word_t'($signed(a) >>> shamt);
         // variable shifts, rt on b shifted by rs
         mips_pkg::ALU_SLLV: result = b << var_amt;
         mips_pkg::ALU_SRLV: result = b >> var_amt;
         mips_pkg::ALU_SRAV: result = mips_pkg::word_t'($signed(b) >>> var_amt);
         mips_pkg::ALU_AND:  result = a & b;
         mips_pkg::ALU_OR:   result = a | b;
         mips_pkg::ALU_XOR:  result = a ^ b;
         mips_pkg::ALU_NOR:  result = ~(a | b);
         mips_pkg::ALU_SLT:  result = {31'b0, lt};
         default:            result = '0; // unused codes
      endcase
   end

endmodule

`default_nettype wire

//--- mips_regfile.sv
// 32 x 32-bit register file, two operand read ports plus a v0 port, one write port
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::reg_idx_t rs_idx,
   input  mips_pkg::reg_idx_t rt_idx,
   output mips_pkg::word_t    rs_data,
   output mips_pkg::word_t    rt_data,
   output mips_pkg::word_t    v0_data,
   input  logic               wr_en,
   input  mips_pkg::reg_idx_t wr_idx,
   input  mips_pkg::word_t    wr_data
);

   mips_pkg::word_t regs [32];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && (wr_idx != '0)) begin // r0 stays zero
         regs[wr_idx] <= wr_data;
      end
   end

   // reads are combinational, same-cycle write not visible
   assign rs_data = regs[rs_idx];
   assign rt_data = regs[rt_idx];
   assign v0_data = regs[mips_pkg::V0_REG]; // syscall argument

endmodule

`default_nettype wire

//--- mips_decode.sv
// instruction decoder, slices fields and builds the control struct for the core
`timescale 1ns/1ps
`default_nettype none

module mips_decode (
   input  mips_pkg::word_t   inst,
   output mips_pkg::fields_t fields,
   output mips_pkg::ctrl_t   ctrl
);

   // field slicing, fixed mips layout
   assign fields.op     = mips_pkg::opcode_t'(inst[31:26]);
   assign fields.rs     = inst[25:21];
   assign fields.rt     = inst[20:16];
   assign fields.rd     = inst[15:11];
   assign fields.shamt  = inst[10:6];
   assign fields.funct  = mips_pkg::funct_t'(inst[5:0]);
   assign fields.imm    = inst[15:0];
   assign fields.target = inst[25:0];

   always_comb begin
      ctrl = '0; // unknown encodings fall through as no-op
      case (fields.op)
         mips_pkg::OP_RTYPE: begin
            ctrl.dst_rd = 1'b1;
            ctrl.reg_we = 1'b1; // cleared below for jr / syscall / unknown
            case (fields.funct)
               mips_pkg::FN_ADD,
               mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
               mips_pkg::FN_SUB,
               mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
               mips_pkg::FN_XOR:  ctrl.alu_op = mips_pkg::ALU_XOR;
               mips_pkg::FN_NOR:  ctrl.alu_op = mips_pkg::ALU_NOR;
               mips_pkg::FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
               mips_pkg::FN_SLL: begin
                  ctrl.alu_op    = mips_pkg::ALU_SLL;
                  ctrl.shift_imm = 1'b1;
               end
               mips_pkg::FN_SRL: begin
                  ctrl.alu_op    = mips_pkg::ALU_SRL;
                  ctrl.shift_imm = 1'b1;
               end
               mips_pkg::FN_SRA: begin
                  ctrl.alu_op    = mips_pkg::ALU_SRA;
                  ctrl.shift_imm = 1'b1;
               end
               mips_pkg::FN_SLLV: ctrl.alu_op = mips_pkg::ALU_SLLV;
               mips_pkg::FN_SRLV: ctrl.alu_op = mips_pkg::ALU_SRLV;
               mips_pkg::FN_SRAV: ctrl.alu_op = mips_pkg::ALU_SRAV;
               mips_pkg::FN_JR: begin
                  ctrl.reg_we   = 1'b0;
                  ctrl.jump_reg = 1'b1;
               end
               mips_pkg::FN_JALR: begin
                  ctrl.jump_reg = 1'b1;
                  ctrl.wb_sel   = mips_pkg::WB_LINK; // link into rd
               end
               mips_pkg::FN_SYSCALL: begin
                  ctrl.reg_we  = 1'b0;
                  ctrl.syscall = 1'b1;
               end
               default: ctrl = '0;
            endcase
         end
         mips_pkg::OP_ADDI,
         mips_pkg::OP_ADDIU: begin
            ctrl.reg_we   = 1'b1;
            ctrl.use_imm  = 1'b1;
            ctrl.sign_ext = 1'b1;
         end
         mips_pkg::OP_SLTI: begin
            ctrl.alu_op   = mips_pkg::ALU_SLT;
            ctrl.reg_we   = 1'b1;
            ctrl.use_imm  = 1'b1;
            ctrl.sign_ext = 1'b1;
         end
         mips_pkg::OP_ANDI: begin
            ctrl.alu_op  = mips_pkg::ALU_AND;
            ctrl.reg_we  = 1'b1;
            ctrl.use_imm = 1'b1; // zero extended
         end
         mips_pkg::OP_ORI: begin
            ctrl.alu_op  = mips_pkg::ALU_OR;
            ctrl.reg_we  = 1'b1;
            ctrl.use_imm = 1'b1;
         end
         mips_pkg::OP_XORI: begin
            ctrl.alu_op  = mips_pkg::ALU_XOR;
            ctrl.reg_we  = 1'b1;
            ctrl.use_imm = 1'b1;
         end
         mips_pkg::OP_LUI: begin
            ctrl.reg_we = 1'b1;
            ctrl.lui    = 1'b1;
         end
         mips_pkg::OP_LW: begin
            ctrl.reg_we   = 1'b1;
            ctrl.use_imm  = 1'b1; // base plus offset
            ctrl.sign_ext = 1'b1;
            ctrl.wb_sel   = mips_pkg::WB_LOAD;
         end
         mips_pkg::OP_SW: begin
            ctrl.mem_we   = 1'b1;
            ctrl.use_imm  = 1'b1;
            ctrl.sign_ext = 1'b1;
         end
         mips_pkg::OP_BEQ: ctrl.branch = 1'b1;
         mips_pkg::OP_BNE: begin
            ctrl.branch    = 1'b1;
            ctrl.branch_ne = 1'b1;
         end
         mips_pkg::OP_J: ctrl.jump = 1'b1;
         mips_pkg::OP_JAL: begin
            ctrl.jump   = 1'b1;
            ctrl.reg_we = 1'b1;
            ctrl.link   = 1'b1;
            ctrl.wb_sel = mips_pkg::WB_LINK;
         end
         default: ctrl = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- mips_fetch.sv
// pc register, next-pc selection and halt flag of the single-cycle core
`timescale 1ns/1ps
`default_nettype none

module mips_fetch #(
   parameter mips_pkg::word_t text_start = 32'h0040_0000
) (
   input  logic              clk,
   input  logic              rst_b,
   input  mips_pkg::ctrl_t   ctrl,
   input  mips_pkg::fields_t fields,
   input  mips_pkg::word_t   rs_data,
   input  logic              rs_eq_rt,
   input  logic              syscall_exit,
   output mips_pkg::word_t   pc,
   output mips_pkg::word_t   link_addr,
   output logic              halted
);

   mips_pkg::word_t   pc_plus4;
   mips_pkg::word_t   br_target;
   mips_pkg::word_t   j_target;
   mips_pkg::word_t   next_pc;
   mips_pkg::pc_sel_t pc_sel;
   logic              br_taken;

   assign pc_plus4  = pc + 32'd4;
   assign link_addr = pc + 32'd8; // jal / jalr return point
   assign br_target = pc_plus4 + {{14{fields.imm[15]}}, fields.imm, 2'b00};
   assign j_target  = {pc[31:28], fields.target, 2'b00}; // same 256MB region

   assign br_taken = ctrl.branch & (rs_eq_rt ^ ctrl.branch_ne); // bne inverts

   always_comb begin
      if (ctrl.jump_reg)   pc_sel = mips_pkg::PC_REG;
      else if (ctrl.jump)  pc_sel = mips_pkg::PC_JUMP;
      else if (br_taken)   pc_sel = mips_pkg::PC_BRANCH;
      else                 pc_sel = mips_pkg::PC_SEQ;
   end

   always_comb begin
      case (pc_sel)
         mips_pkg::PC_BRANCH: next_pc = br_target;
         mips_pkg::PC_REG:    next_pc = rs_data;
         mips_pkg::PC_JUMP:   next_pc = j_target;
         default:             next_pc = pc_plus4;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc     <= text_start;
         halted <= 1'b0;
      end else if (!halted) begin // frozen once halted
         pc     <= next_pc;
         halted <= syscall_exit;  // sticky until reset
      end
   end

endmodule

`default_nettype wire

//--- mips_core.sv
// single-cycle mips core top, one instruction retired per clock edge
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
   parameter mips_pkg::word_t text_start = 32'h0040_0000 // reset pc
) (
   input  logic            clk,
   input  logic            rst_b,
   output logic [29:0]     inst_addr,    // word address
   input  mips_pkg::word_t inst,
   output logic [29:0]     mem_addr,     // word address
   output mips_pkg::word_t mem_data_in,  // store data
   output logic [3:0]      mem_write_en, // byte strobes
   input  mips_pkg::word_t mem_data_out, // load data
   output logic            halted
);

   mips_pkg::fields_t  fields;
   mips_pkg::ctrl_t    ctrl;
   mips_pkg::word_t    pc, link_addr;
   mips_pkg::word_t    rs_data, rt_data, v0_data;
   mips_pkg::word_t    imm_ext, alu_a, alu_b, alu_result;
   mips_pkg::word_t    wr_data;
   mips_pkg::reg_idx_t wr_idx;
   logic               syscall_exit;
   logic               reg_we;

   mips_decode u_decode (.inst(inst), .fields(fields), .ctrl(ctrl));

   mips_fetch #(.text_start(text_start)) u_fetch (
      .clk(clk), .rst_b(rst_b), .ctrl(ctrl), .fields(fields),
      .rs_data(rs_data), .rs_eq_rt(rs_data == rt_data),
      .syscall_exit(syscall_exit), .pc(pc), .link_addr(link_addr),
      .halted(halted)
   );

   mips_regfile u_regfile (
      .clk(clk), .rst_b(rst_b), .rs_idx(fields.rs), .rt_idx(fields.rt),
      .rs_data(rs_data), .rt_data(rt_data), .v0_data(v0_data),
      .wr_en(reg_we), .wr_idx(wr_idx), .wr_data(wr_data)
   );

   // operand selection
   assign imm_ext = ctrl.sign_ext ? {{16{fields.imm[15]}}, fields.imm} : {16'h0, fields.imm};
   assign alu_a   = ctrl.shift_imm ? rt_data : rs_data; // shamt shifts work on rt
   assign alu_b   = ctrl.use_imm ? imm_ext : rt_data;

   mips_alu u_alu (
      .op(ctrl.alu_op), .a(alu_a), .b(alu_b), .shamt(fields.shamt),
      .result(alu_result)
   );

   // destination, r31 for jal
   always_comb begin
      if (ctrl.link)        wr_idx = mips_pkg::RA_REG;
      else if (ctrl.dst_rd) wr_idx = fields.rd;
      else                  wr_idx = fields.rt;
   end

   // write-back source
   always_comb begin
      if (ctrl.lui) begin
         wr_data = {fields.imm, 16'h0};
      end else begin
         case (ctrl.wb_sel)
            mips_pkg::WB_LOAD: wr_data = mem_data_out;
            mips_pkg::WB_LINK: wr_data = link_addr;
            default:           wr_data = alu_result;
         endcase
      end
   end

   assign syscall_exit = ctrl.syscall && (v0_data == mips_pkg::SYSCALL_EXIT);

   // no architectural writes once halted
   assign reg_we       = ctrl.reg_we & ~halted;
   assign mem_write_en = {4{ctrl.mem_we & ~halted}}; // word stores only

   assign inst_addr   = pc[31:2];
   assign mem_addr    = alu_result[31:2];
   assign mem_data_in = rt_data;

endmodule

`default_nettype wire

//--- mips_core_props.sv
// concurrent rule checks for mips_core, attached to the core by bind from the testbench
`timescale 1ns/1ps
`default_nettype none

module mips_core_props #(
   parameter mips_pkg::word_t text_start = 32'h0040_0000
) (
   input logic            clk,
   input logic            rst_b,
   input logic [29:0]     inst_addr,
   input logic [3:0]      mem_write_en,
   input logic            halted,
   input logic            reg_we,
   input mips_pkg::ctrl_t ctrl
);

   logic redirect;     // any decoded change of flow
   int   failures = 0; // failed rule count, summed into the testbench errors

   assign redirect = ctrl.branch | ctrl.jump | ctrl.jump_reg;

   // pc sits on text_start while reset is held
   reset_values: assert property (@(posedge clk)
      !rst_b |-> (inst_addr == text_start[31:2]) && !halted)
      else begin
         $error("pc or halt flag wrong during reset");
         failures++;
      end

   // plain instructions step one word
   pc_step: assert property (@(posedge clk) disable iff (!rst_b)
      (!halted && !redirect) |=> inst_addr == $past(inst_addr) + 30'd1)
      else begin
         $error("pc did not step by one word");
         failures++;
      end

   // word stores only
   strobe_shape: assert property (@(posedge clk) disable iff (!rst_b)
      (mem_write_en == 4'h0) || (mem_write_en == 4'hf))
      else begin
         $error("partial store strobe");
         failures++;
      end

   halt_sticky: assert property (@(posedge clk) disable iff (!rst_b) halted |=> halted)
      else begin
         $error("halt flag dropped");
         failures++;
      end

   halt_freeze: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> $stable(inst_addr))
      else begin
         $error("pc moved while halted");
         failures++;
      end

   halt_quiet: assert property (@(posedge clk) disable iff (!rst_b)
      halted |-> (mem_write_en == 4'h0) && !reg_we)
      else begin
         $error("write while halted");
         failures++;
      end

endmodule

`default_nettype wire

//--- tb_mips_core.sv
// testbench for mips_core, builds programs in memory and checks stores and control flow
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

   localparam mips_pkg::word_t TEXT_START = 32'h0040_0000;
   localparam logic [29:0]     TEXT_WORD  = TEXT_START[31:2];
   localparam int              TIMEOUT    = 2000; // cycles per program
   localparam int              FN_IDX     = 200;  // subroutine slot for jal

   logic            clk;
   logic            rst_b;
   logic [29:0]     inst_addr, mem_addr;
   mips_pkg::word_t inst, mem_data_in, mem_data_out;
   logic [3:0]      mem_write_en;
   logic            halted;

   mips_pkg::word_t imem [256];
   mips_pkg::word_t dmem [256];
   mips_pkg::word_t model [32];   // reference register state
   logic [29:0]     exp_addr [$]; // expected stores in order
   mips_pkg::word_t exp_data [$];
   int              next_idx [int]; // flow checks, from index to next index
   int              pc_idx, daddr, halt_idx;
   int              errors, checks, tests;
   logic [31:0]     rng;
   logic            have_pend;
   logic [29:0]     pend_addr;

   mips_core #(.text_start(TEXT_START)) UUT (
      .clk(clk), .rst_b(rst_b), .inst_addr(inst_addr), .inst(inst),
      .mem_addr(mem_addr), .mem_data_in(mem_data_in), .mem_write_en(mem_write_en),
      .mem_data_out(mem_data_out), .halted(halted)
   );

   bind mips_core mips_core_props #(.text_start(text_start)) u_props (
      .clk(clk), .rst_b(rst_b), .inst_addr(inst_addr), .mem_write_en(mem_write_en),
      .halted(halted), .reg_we(reg_we), .ctrl(ctrl)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk; // 100 ns period

   // combinational memories, 256 words each
   assign inst         = imem[inst_addr[7:0]];
   assign mem_data_out = dmem[mem_addr[7:0]];

   // store monitor and data memory write
   always @(posedge clk) begin
      if (rst_b && mem_write_en != 4'h0) begin
         if (exp_addr.size() == 0) begin
            $display("unexpected store at time %0t to word %h", $time, mem_addr);
            errors++;
         end else begin
            checks++;
            assert (mem_addr == exp_addr[0]) else begin
               $display("ERR t=%0t mem_addr got %h exp %h", $time, mem_addr, exp_addr[0]);
               errors++;
            end
            assert (mem_data_in == exp_data[0]) else begin
               $display("ERR t=%0t mem_data_in got %h exp %h", $time, mem_data_in, exp_data[0]);
               errors++;
            end
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
         end
         dmem[mem_addr[7:0]] <= #1 mem_data_in;
      end
   end

   // branch and jump targets
   always @(posedge clk) begin
      if (!rst_b) begin
         have_pend = 1'b0;
      end else begin
         if (have_pend) begin
            checks++;
            assert (inst_addr == pend_addr) else begin
               $display("ERR t=%0t inst_addr got %h exp %h", $time, inst_addr, pend_addr);
               errors++;
            end
         end
         have_pend = 1'b0;
         if (!halted && next_idx.exists(int'(inst_addr - TEXT_WORD))) begin
            have_pend = 1'b1;
            pend_addr = TEXT_WORD + 30'(next_idx[int'(inst_addr - TEXT_WORD)]);
         end
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [31:0] rand32();
      rng = xorshift(rng);
      return rng;
   endfunction

   // instruction encoders
   function automatic mips_pkg::word_t enc_r(input mips_pkg::funct_t fn, input int rs, rt, rd,
                                             input int sh);
      return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
   endfunction

   function automatic mips_pkg::word_t enc_i(input mips_pkg::opcode_t op, input int rs, rt,
                                             input logic [15:0] imm);
      return {op, 5'(rs), 5'(rt), imm};
   endfunction

   function automatic mips_pkg::word_t enc_j(input mips_pkg::opcode_t op, input int idx);
      mips_pkg::word_t a;
      a = TEXT_START + 32'(idx * 4);
      return {op, a[27:2]}; // pseudo-direct target
   endfunction

   // reference results from the mips rules
   function automatic mips_pkg::word_t ref_r(input mips_pkg::funct_t fn,
                                             input mips_pkg::word_t a, b, input int sh);
      case (fn)
         mips_pkg::FN_ADD, mips_pkg::FN_ADDU: return a + b;
         mips_pkg::FN_SUB, mips_pkg::FN_SUBU: return a - b;
         mips_pkg::FN_AND:  return a & b;
         mips_pkg::FN_OR:   return a | b;
         mips_pkg::FN_XOR:  return a ^ b;
         mips_pkg::FN_NOR:  return ~(a | b);
         mips_pkg::FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         mips_pkg::FN_SLL:  return b << sh[4:0];
         mips_pkg::FN_SRL:  return b >> sh[4:0];
         mips_pkg::FN_SRA:  return $signed(b) >>> sh[4:0];
         mips_pkg::FN_SLLV: return b << a[4:0];
         mips_pkg::FN_SRLV: return b >> a[4:0];
         mips_pkg::FN_SRAV: return $signed(b) >>> a[4:0];
         default:           return 32'h0;
      endcase
   endfunction

   function automatic mips_pkg::word_t ref_i(input mips_pkg::opcode_t op,
                                             input mips_pkg::word_t a, input logic [15:0] imm);
      mips_pkg::word_t se, ze;
      se = {{16{imm[15]}}, imm};
      ze = {16'h0, imm};
      case (op)
         mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: return a + se;
         mips_pkg::OP_SLTI: return ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
         mips_pkg::OP_ANDI: return a & ze;
         mips_pkg::OP_ORI:  return a | ze;
         mips_pkg::OP_XORI: return a ^ ze;
         default:           return a;
      endcase
   endfunction

   // program builder, keeps the reference registers in step
   task automatic emit(input mips_pkg::word_t w);
      imem[pc_idx] = w;
      pc_idx++;
   endtask

   task automatic set_reg(input int r, input mips_pkg::word_t v);
      emit(enc_i(mips_pkg::OP_LUI, 0, r, v[31:16]));
      emit(enc_i(mips_pkg::OP_ORI, r, r, v[15:0]));
      if (r != 0) model[r] = v;
   endtask

   task automatic do_r(input mips_pkg::funct_t fn, input int rd, rs, rt, sh);
      emit(enc_r(fn, rs, rt, rd, sh));
      if (rd != 0) model[rd] = ref_r(fn, model[rs], model[rt], sh);
   endtask

   task automatic do_i(input mips_pkg::opcode_t op, input int rt, rs, input logic [15:0] imm);
      emit(enc_i(op, rs, rt, imm));
      if (rt != 0) model[rt] = ref_i(op, model[rs], imm);
   endtask

   task automatic store_reg(input int r);
      emit(enc_i(mips_pkg::OP_SW, 0, r, 16'(daddr * 4)));
      exp_addr.push_back(30'(daddr));
      exp_data.push_back(model[r]);
      daddr++;
   endtask

   task automatic poison();
      emit(enc_i(mips_pkg::OP_SW, 0, 0, 16'h03fc)); // never expected, flags a wrong path
   endtask

   task automatic branch_over(input mips_pkg::opcode_t op, input int rs, rt);
      logic taken;
      taken = (model[rs] == model[rt]) ^ (op == mips_pkg::OP_BNE);
      next_idx[pc_idx] = taken ? pc_idx + 2 : pc_idx + 1;
      emit(enc_i(op, rs, rt, 16'd1));
      if (taken) poison();
      else do_i(mips_pkg::OP_ADDI, 11, 11, 16'd1); // counts fall-throughs
   endtask

   task automatic jal_call();
      int idx;
      idx = pc_idx;
      next_idx[idx] = FN_IDX;
      emit(enc_j(mips_pkg::OP_JAL, FN_IDX));
      poison();
      model[31] = TEXT_START + 32'(idx * 4 + 8);
      // subroutine stores ra then returns
      imem[FN_IDX]     = enc_i(mips_pkg::OP_SW, 0, 31, 16'(daddr * 4));
      imem[FN_IDX + 1] = enc_r(mips_pkg::FN_JR, 31, 0, 0, 0);
      next_idx[FN_IDX + 1] = idx + 2;
      exp_addr.push_back(30'(daddr));
      exp_data.push_back(model[31]);
      daddr++;
   endtask

   task automatic begin_program();
      for (int i = 0; i < 256; i++) begin
         imem[i] = 32'h0;
         dmem[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'hc3};
      end
      for (int i = 0; i < 32; i++) model[i] = 32'h0;
      exp_addr.delete();
      exp_data.delete();
      next_idx.delete();
      pc_idx = 0;
      daddr  = 0;
      #1 rst_b = 1'b0;
   endtask

   task automatic run_program(input string name, input logic store_after_halt);
      int cyc;
      logic [29:0] frozen;
      set_reg(2, mips_pkg::SYSCALL_EXIT);
      halt_idx = pc_idx;
      emit(enc_r(mips_pkg::FN_SYSCALL, 0, 0, 0, 0));
      if (store_after_halt) poison(); // sits on the frozen pc, strobe must stay off
      repeat (8) @(posedge clk);
      #1 rst_b = 1'b1;
      checks += 2;
      assert (inst_addr == TEXT_WORD) else begin
         $display("ERR t=%0t inst_addr got %h exp %h", $time, inst_addr, TEXT_WORD);
         errors++;
      end
      assert (!halted) else begin
         $display("ERR t=%0t halted got %b exp 0", $time, halted);
         errors++;
      end
      cyc = 0;
      while (!halted && cyc < TIMEOUT) begin
         @(posedge clk);
         cyc++;
      end
      if (!halted) begin
         $display("timeout, core never halted in test %0s", name);
         $display("TEST FAIL");
         $finish;
      end else begin
         frozen = inst_addr;
         cyc = 0;
         while (cyc < 4) begin // watch a few halted cycles
            @(posedge clk);
            cyc++;
         end
         checks++;
         assert (inst_addr == frozen && frozen == TEXT_WORD + 30'(halt_idx + 1)) else begin
            $display("ERR t=%0t inst_addr got %h exp %h", $time, inst_addr,
                     TEXT_WORD + 30'(halt_idx + 1));
            errors++;
         end
         if (exp_addr.size() != 0) begin
            $display("%0d expected stores never happened in test %0s", exp_addr.size(), name);
            errors++;
         end
         tests++;
         $display("test %0s finished, %0d errors so far", name, errors);
      end
   endtask

   initial begin
      mips_pkg::funct_t  rfn [15];
      mips_pkg::opcode_t ifn [6];
      mips_pkg::word_t   x, preset;
      rst_b  = 1'b1; // pulled low by begin_program
      errors = 0;
      checks = 0;
      tests  = 0;
      rng    = 32'd51173;
      have_pend = 1'b0;
      rfn = '{mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB, mips_pkg::FN_SUBU,
              mips_pkg::FN_AND, mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_NOR,
              mips_pkg::FN_SLT, mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA,
              mips_pkg::FN_SLLV, mips_pkg::FN_SRLV, mips_pkg::FN_SRAV};
      ifn = '{mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI,
              mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI};

      begin_program(); // reset only, straight to halt
      run_program("reset", 1'b0);

      begin_program();
      foreach (rfn[i]) begin
         set_reg(8, rand32());
         set_reg(9, rand32());
         do_r(rfn[i], 10, 8, 9, int'(rand32() & 31));
         store_reg(10);
      end
      foreach (ifn[i]) begin
         set_reg(8, rand32());
         do_i(ifn[i], 10, 8, 16'(rand32()));
         store_reg(10);
      end
      run_program("alu", 1'b0);

      begin_program();
      preset = rand32();
      dmem[100] = preset;
      x = rand32() & 32'h7fff;
      emit(enc_i(mips_pkg::OP_LW, 0, 8, 16'd400));
      model[8] = preset;
      do_i(mips_pkg::OP_ADDI, 8, 8, x[15:0]);
      store_reg(8);
      do_i(mips_pkg::OP_ADDI, 0, 0, 16'd5); // r0 ignores writes
      store_reg(0);
      run_program("load", 1'b0);

      begin_program();
      x = rand32();
      set_reg(8, x);
      set_reg(9, x);
      set_reg(12, x ^ 32'h1);
      branch_over(mips_pkg::OP_BEQ, 8, 9);
      branch_over(mips_pkg::OP_BEQ, 8, 12);
      branch_over(mips_pkg::OP_BNE, 8, 12);
      branch_over(mips_pkg::OP_BNE, 8, 9);
      store_reg(11);
      next_idx[pc_idx] = pc_idx + 2;
      emit(enc_j(mips_pkg::OP_J, pc_idx + 2));
      poison();
      jal_call();
      store_reg(31);
      run_program("flow", 1'b0);

      begin_program();
      set_reg(2, 32'd7);
      emit(enc_r(mips_pkg::FN_SYSCALL, 0, 0, 0, 0)); // v0 not 10, keeps going
      store_reg(2);
      run_program("syscall", 1'b1);

      errors += UUT.u_props.failures; // concurrent rule failures
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- mips_core.f
mips_pkg.sv
mips_alu.sv
mips_regfile.sv
mips_decode.sv
mips_fetch.sv
mips_core.sv
mips_core_props.sv
tb_mips_core.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mips_core
FILELIST   := mips_core.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
